/* common/calc_consts.svh */
// Calculator constants: number width, key FIFO depth, multiplier iteration count
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// Sign in the top bit, magnitude below it
`define CALC_WIDTH 16

`define KEY_FIFO_DEPTH 4

// One iteration per magnitude bit
`define MULT_CYCLES 15

`endif

/* common/calc_pkg.sv */
// Calculator types: opcode and key-kind enums, key event struct, controller state enum
package calc_pkg;

    // Operator keys and the latched operation
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_OP,
        KEY_EQUAL
    } key_kind_t;

    // One keypad press, 9 bits
    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;
        op_t        op;
    } key_event_t;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT
    } calc_state_t;

endpackage

/* source/key_encoder.sv */
// Key encoder: rising-edge detection and priority encoding of keypad buttons
module key_encoder (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [9:0]            digit_pad,
    input  logic [3:0]            op_pad,
    input  logic                  equal_btn,
    output logic                  push_valid,
    output calc_pkg::key_event_t  push_event
);
    import calc_pkg::*;

    logic [9:0] digit_q;
    logic [3:0] op_q;
    logic       equal_q;
    logic [9:0] digit_rise;
    logic [3:0] op_rise;
    logic       equal_rise;
    key_event_t enc;

    assign digit_rise = digit_pad & ~digit_q;
    assign op_rise    = op_pad & ~op_q;
    assign equal_rise = equal_btn & ~equal_q;

    // Equal wins, then NEG..MUL, then the lowest digit
    // op_pad bit 0 is NEG, bit 3 is MUL
    always_comb begin
        enc.kind  = KEY_DIGIT;
        enc.digit = 4'd0;
        enc.op    = OP_NONE;
        for (int i = 9; i >= 0; i--) begin
            if (digit_rise[i]) enc.digit = 4'(i);
        end
        for (int i = 3; i >= 0; i--) begin
            if (op_rise[i]) begin
                enc.kind = KEY_OP;
                enc.op   = op_t'(3'(i + 1));
            end
        end
        if (equal_rise) begin
            enc.kind = KEY_EQUAL;
            enc.op   = OP_NONE;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            digit_q    <= '0;
            op_q       <= '0;
            equal_q    <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            digit_q    <= digit_pad;
            op_q       <= op_pad;
            equal_q    <= equal_btn;
            push_valid <= |{digit_rise, op_rise, equal_rise};
        end
    end

    always_ff @(posedge clk) begin
        push_event <= enc;
    end

endmodule

/* source/key_fifo.sv */
// Key event FIFO: circular buffer with valid/ready pop side and sticky drop flag
`include "calc_consts.svh"

module key_fifo #(
    parameter int DEPTH = `KEY_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  push_valid,
    input  calc_pkg::key_event_t  push_event,
    output logic                  pop_valid,
    output calc_pkg::key_event_t  pop_event,
    input  logic                  pop_ready,
    output logic                  dropped
);
    import calc_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    key_event_t    mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push_ok;
    logic          pop_ok;

    // Wraps at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop_valid = (count != '0);
    assign pop_event = mem[rd_ptr];
    assign push_ok   = push_valid && (count != FULL);
    assign pop_ok    = pop_valid && pop_ready;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            if (push_ok) wr_ptr <= bump(wr_ptr);
            if (pop_ok) rd_ptr <= bump(rd_ptr);
            count <= count + CW'(push_ok) - CW'(pop_ok);
            // Full buffer loses the press
            if (push_valid && !push_ok) dropped <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) mem[wr_ptr] <= push_event;
    end

    count_bound: assert property (@(posedge clk) disable iff (!nRST) count <= FULL);

endmodule

/* gencon/addition.sv */
// Sign-magnitude adder/subtractor with start/finish handshake
`include "calc_consts.svh"

module addition (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [`CALC_WIDTH-1:0] in1,
    input  logic [`CALC_WIDTH-1:0] in2,
    input  logic                   sub,
    input  logic                   start,
    output logic [`CALC_WIDTH-1:0] out,
    output logic                   finish
);
    localparam int MW = `CALC_WIDTH - 1;

    logic          s1;
    logic          s2;
    logic          res_sign;
    logic [MW-1:0] m1;
    logic [MW-1:0] m2;
    logic [MW-1:0] res_mag;

    always_comb begin
        s1 = in1[MW];
        s2 = in2[MW] ^ sub;
        m1 = in1[MW-1:0];
        m2 = in2[MW-1:0];
        if (s1 == s2) begin
            res_mag  = m1 + m2;
            res_sign = s1;
        end else if (m1 >= m2) begin
            res_mag  = m1 - m2;
            res_sign = s1;
        end else begin
            res_mag  = m2 - m1;
            res_sign = s2;
        end
        // No negative zero
        if (res_mag == '0) res_sign = 1'b0;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) finish <= 1'b0;
        else finish <= start;
    end

    always_ff @(posedge clk) begin
        if (start) out <= {res_sign, res_mag};
    end

endmodule

/* gencon/multiply.sv */
// Sequential shift-add sign-magnitude multiplier with start/finish handshake
`include "calc_consts.svh"

module multiply (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [`CALC_WIDTH-1:0] in1,
    input  logic [`CALC_WIDTH-1:0] in2,
    input  logic                   start,
    output logic [`CALC_WIDTH-1:0] out,
    output logic                   finish
);
    localparam int MW = `CALC_WIDTH - 1;
    localparam int CW = $clog2(`MULT_CYCLES + 1);

    logic [CW-1:0] cnt;
    logic          busy;
    logic          sign_q;
    logic [MW-1:0] a_q;
    logic [MW-1:0] b_q;
    logic [MW-1:0] acc_q;
    logic [MW-1:0] acc_next;

    assign busy     = (cnt != '0);
    assign acc_next = b_q[0] ? acc_q + a_q : acc_q;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            cnt    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                cnt <= CW'(`MULT_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CW'(1)) finish <= 1'b1;
            end
        end
    end

    // Bits shifted past the top are lost, so the product wraps
    always_ff @(posedge clk) begin
        if (start) begin
            a_q    <= in1[MW-1:0];
            b_q    <= in2[MW-1:0];
            acc_q  <= '0;
            sign_q <= in1[MW] ^ in2[MW];
        end else if (busy) begin
            acc_q <= acc_next;
            a_q   <= a_q << 1;
            b_q   <= b_q >> 1;
            if (cnt == CW'(1)) out <= {sign_q && (acc_next != '0), acc_next};
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !busy);

endmodule

/* gencon/gencon.sv */
// Calculator controller: operand entry, operation dispatch and result display
`include "calc_consts.svh"

module gencon (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   key_valid,
    input  calc_pkg::key_event_t   key_event,
    output logic                   key_read,
    output logic                   complete,
    output logic [`CALC_WIDTH-1:0] display_output
);
    import calc_pkg::*;

    localparam int W  = `CALC_WIDTH;
    localparam int MW = W - 1;

    calc_state_t   state;
    calc_state_t   next_state;
    op_t           op_q;
    logic [3:0]    digit_q;
    logic [W-1:0]  operand1;
    logic [W-1:0]  operand2;
    logic [W-1:0]  cur_operand;
    logic [W-1:0]  cur_next;
    logic          cur_we;
    logic          in_op2;
    logic          take;
    logic          is_binop;

    logic          start_alu;
    logic          alu_sub;
    logic [W-1:0]  alu_out;
    logic          alu_finish;
    logic          start_mult;
    logic [W-1:0]  mult_a;
    logic [W-1:0]  mult_b;
    logic [W-1:0]  mult_out;
    logic          mult_finish;

    addition add_calc (
        .clk    (clk),
        .nRST   (nRST),
        .in1    (operand1),
        .in2    (operand2),
        .sub    (alu_sub),
        .start  (start_alu),
        .out    (alu_out),
        .finish (alu_finish)
    );

    multiply mult_calc (
        .clk    (clk),
        .nRST   (nRST),
        .in1    (mult_a),
        .in2    (mult_b),
        .start  (start_mult),
        .out    (mult_out),
        .finish (mult_finish)
    );

    // Keys are taken only while waiting for input
    assign key_read    = key_valid && (state inside {WAIT_OP1, WAIT_OP2});
    assign take        = key_read;
    assign is_binop    = key_event.op inside {OP_ADD, OP_SUB, OP_MUL};
    assign in_op2      = state inside {WAIT_OP2, WAIT_MULT_OP2, ADD_KEY_OP2};
    assign cur_operand = in_op2 ? operand2 : operand1;
    assign alu_sub     = (op_q == OP_SUB);

    // Digit entry multiplies the bare magnitude by ten, sign stays in the operand
    always_comb begin
        if (state == WAIT_COMPUTE) begin
            mult_a = operand1;
            mult_b = operand2;
        end else begin
            mult_a = {1'b0, cur_operand[MW-1:0]};
            mult_b = W'(10);
        end
    end

    always_comb begin
        next_state = state;
        cur_next   = cur_operand;
        cur_we     = 1'b0;
        case (state)
            WAIT_OP1, WAIT_OP2: begin
                if (take) begin
                    case (key_event.kind)
                        KEY_DIGIT: next_state = in_op2 ? WAIT_MULT_OP2 : WAIT_MULT_OP1;
                        KEY_OP: begin
                            if (is_binop) next_state = WAIT_OP2;
                            if (key_event.op == OP_NEG) begin
                                cur_next[MW] = ~cur_operand[MW];
                                cur_we       = 1'b1;
                            end
                        end
                        // A stray equal before any operator is dropped here
                        KEY_EQUAL: if (in_op2) next_state = SEND_TO_COMPUTE;
                        default: ;
                    endcase
                end
            end
            WAIT_MULT_OP1, WAIT_MULT_OP2: begin
                if (mult_finish) begin
                    next_state          = in_op2 ? ADD_KEY_OP2 : ADD_KEY_OP1;
                    cur_next[MW-1:0]    = mult_out[MW-1:0];
                    cur_we              = 1'b1;
                end
            end
            ADD_KEY_OP1, ADD_KEY_OP2: begin
                next_state       = in_op2 ? WAIT_OP2 : WAIT_OP1;
                cur_next[MW-1:0] = cur_operand[MW-1:0] + MW'(digit_q);
                cur_we           = 1'b1;
            end
            SEND_TO_COMPUTE: next_state = WAIT_COMPUTE;
            WAIT_COMPUTE: begin
                if ((op_q == OP_MUL) ? mult_finish : alu_finish) next_state = SHOW_RESULT;
            end
            SHOW_RESULT: next_state = WAIT_OP1;
            default: next_state = WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= WAIT_OP1;
            op_q           <= OP_NONE;
            operand1       <= '0;
            operand2       <= '0;
            start_alu      <= 1'b0;
            start_mult     <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state      <= next_state;
            start_alu  <= 1'b0;
            start_mult <= 1'b0;
            complete   <= 1'b0;
            if (take && key_event.kind == KEY_DIGIT) start_mult <= 1'b1;
            // Later operator replaces the earlier one
            if (take && key_event.kind == KEY_OP && is_binop) op_q <= key_event.op;
            if (cur_we) begin
                if (in_op2) operand2 <= cur_next;
                else operand1 <= cur_next;
            end
            if (state == SEND_TO_COMPUTE) begin
                if (op_q == OP_MUL) start_mult <= 1'b1;
                else start_alu <= 1'b1;
            end
            if (state == SHOW_RESULT) begin
                complete       <= 1'b1;
                display_output <= (op_q == OP_MUL) ? mult_out : alu_out;
                operand1       <= '0;
                operand2       <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && key_event.kind == KEY_DIGIT) digit_q <= key_event.digit;
    end

    complete_single: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete);

    // Adder computation never shares the multiplier
    no_mult_on_add: assert property (@(posedge clk) disable iff (!nRST)
        (state == WAIT_COMPUTE && op_q != OP_MUL) |-> !start_mult);

endmodule

/* source/calc_top.sv */
// Calculator top level: key encoder, key FIFO and controller
`include "calc_consts.svh"

module calc_top (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [9:0]             digit_pad,
    input  logic [3:0]             op_pad,
    input  logic                   equal_btn,
    output logic [`CALC_WIDTH-1:0] display_output,
    output logic                   complete,
    output logic                   key_dropped
);
    import calc_pkg::*;

    logic       push_valid;
    key_event_t push_event;
    logic       pop_valid;
    key_event_t pop_event;
    logic       key_read;

    key_encoder u_encoder (
        .clk        (clk),
        .nRST       (nRST),
        .digit_pad  (digit_pad),
        .op_pad     (op_pad),
        .equal_btn  (equal_btn),
        .push_valid (push_valid),
        .push_event (push_event)
    );

    key_fifo #(.DEPTH(`KEY_FIFO_DEPTH)) u_fifo (
        .clk        (clk),
        .nRST       (nRST),
        .push_valid (push_valid),
        .push_event (push_event),
        .pop_valid  (pop_valid),
        .pop_event  (pop_event),
        .pop_ready  (key_read),
        .dropped    (key_dropped)
    );

    gencon u_gencon (
        .clk            (clk),
        .nRST           (nRST),
        .key_valid      (pop_valid),
        .key_event      (pop_event),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

/* test/calc_checker.sv */
// Calculator reference model: key decode, FIFO and controller timing, result checks
`include "calc_consts.svh"

module calc_checker (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [9:0]             digit_pad,
    input  logic [3:0]             op_pad,
    input  logic                   equal_btn,
    input  logic [`CALC_WIDTH-1:0] display_output,
    input  logic                   complete,
    input  logic                   key_dropped,
    output int                     mismatches,
    output int                     other_errors,
    output int                     results,
    output logic                   busy
);
    timeunit 1ns;
    timeprecision 1ns;
    import calc_pkg::*;

    localparam int W  = `CALC_WIDTH;
    localparam int MW = W - 1;
    // Cycles from taking a key until the next key can be taken
    localparam int DIGIT_LAT = `MULT_CYCLES + 4;
    localparam int ADD_LAT   = 5;
    localparam int MUL_LAT   = `MULT_CYCLES + 5;

    logic [9:0]   digit_prev;
    logic [3:0]   op_prev;
    logic         equal_prev;
    logic         enc_valid;
    key_event_t   enc_event;
    key_event_t   fifo_q[$];
    logic [W-1:0] expect_q[$];
    logic [W-1:0] opnd [2];
    logic [W-1:0] shown;
    logic         in_op2;
    logic         drop_m;
    logic         complete_prev;
    op_t          op_m;
    int           wait_cnt;

    function automatic logic [W-1:0] signed_sum(input logic [W-1:0] a, input logic [W-1:0] b);
        int va;
        int vb;
        int sum;
        int mag;
        va  = a[MW] ? -int'(a[MW-1:0]) : int'(a[MW-1:0]);
        vb  = b[MW] ? -int'(b[MW-1:0]) : int'(b[MW-1:0]);
        sum = va + vb;
        mag = (sum < 0) ? -sum : sum;
        mag = mag % (1 << MW);
        return {(sum < 0) && (mag != 0), MW'(mag)};
    endfunction

    function automatic logic [W-1:0] product(input logic [W-1:0] a, input logic [W-1:0] b);
        longint        p;
        logic [MW-1:0] mag;
        p   = longint'(a[MW-1:0]) * longint'(b[MW-1:0]);
        mag = MW'(p);
        return {(a[MW] ^ b[MW]) && (mag != '0), mag};
    endfunction

    // Equal first, then NEG..MUL, then the lowest digit
    function automatic key_event_t decode(input logic [9:0] d, input logic [3:0] o,
                                          input logic e);
        key_event_t ev;
        logic [9:0] d_left;
        logic [3:0] o_left;
        int         i;
        ev.kind  = KEY_DIGIT;
        ev.digit = 4'd0;
        ev.op    = OP_NONE;
        d_left   = d;
        o_left   = o;
        i        = 0;
        if (e) begin
            ev.kind = KEY_EQUAL;
        end else if (o_left != 4'b0) begin
            while (o_left[0] == 1'b0) begin
                o_left = o_left >> 1;
                i++;
            end
            ev.kind = KEY_OP;
            ev.op   = op_t'(3'(i + 1));
        end else begin
            while (d_left[0] == 1'b0) begin
                d_left = d_left >> 1;
                i++;
            end
            ev.digit = 4'(i);
        end
        return ev;
    endfunction

    task automatic report_mismatch(input string name, input logic [W-1:0] exp,
                                   input logic [W-1:0] act);
        mismatches++;
        $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    endtask

    task automatic take_key(input key_event_t ev);
        logic [W-1:0] res;
        wait_cnt = 0;
        case (ev.kind)
            KEY_DIGIT: begin
                opnd[in_op2][MW-1:0] = MW'(int'(opnd[in_op2][MW-1:0]) * 10 + int'(ev.digit));
                wait_cnt = DIGIT_LAT - 1;
            end
            KEY_OP: begin
                if (ev.op == OP_NEG) begin
                    opnd[in_op2][MW] = ~opnd[in_op2][MW];
                end else begin
                    op_m   = ev.op;
                    in_op2 = 1'b1;
                end
            end
            default: begin
                // Equal with no operator yet is ignored
                if (in_op2) begin
                    if (op_m == OP_MUL) begin
                        res      = product(opnd[0], opnd[1]);
                        wait_cnt = MUL_LAT - 1;
                    end else begin
                        res = signed_sum(opnd[0],
                                         {opnd[1][MW] ^ (op_m == OP_SUB), opnd[1][MW-1:0]});
                        wait_cnt = ADD_LAT - 1;
                    end
                    expect_q.push_back(res);
                    opnd[0] = '0;
                    opnd[1] = '0;
                    in_op2  = 1'b0;
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        logic [W-1:0] exp_val;
        logic [9:0]   d_rise;
        logic [3:0]   o_rise;
        logic         e_rise;
        int           depth_before;
        if (!nRST) begin
            fifo_q.delete();
            expect_q.delete();
            digit_prev    = '0;
            op_prev       = '0;
            equal_prev    = 1'b0;
            enc_valid     = 1'b0;
            opnd[0]       = '0;
            opnd[1]       = '0;
            shown         = '0;
            in_op2        = 1'b0;
            drop_m        = 1'b0;
            complete_prev = 1'b0;
            op_m          = OP_NONE;
            wait_cnt      = 0;
            mismatches    = 0;
            other_errors  = 0;
            results       = 0;
        end else begin
            // Outputs before any press are the reset values held in the model
            if (complete && complete_prev) begin
                other_errors++;
                $display("complete stayed high for two cycles at time %0t", $time);
            end
            if (complete) begin
                if (expect_q.size() == 0) begin
                    other_errors++;
                    $display("complete pulsed at time %0t with no EQUAL waiting", $time);
                end else begin
                    exp_val = expect_q.pop_front();
                    results++;
                    if (display_output !== exp_val)
                        report_mismatch("display_output", exp_val, display_output);
                end
                shown = display_output;
            end else if (display_output !== shown) begin
                report_mismatch("display_output", shown, display_output);
                shown = display_output;
            end
            if (key_dropped !== drop_m) begin
                report_mismatch("key_dropped", W'(drop_m), W'(key_dropped));
                drop_m = key_dropped;
            end

            // Controller pops before the FIFO takes this cycle's push
            depth_before = fifo_q.size();
            if (wait_cnt > 0) wait_cnt--;
            else if (depth_before > 0) take_key(fifo_q.pop_front());
            if (enc_valid) begin
                if (depth_before < `KEY_FIFO_DEPTH) fifo_q.push_back(enc_event);
                else drop_m = 1'b1;
            end

            d_rise     = digit_pad & ~digit_prev;
            o_rise     = op_pad & ~op_prev;
            e_rise     = equal_btn & ~equal_prev;
            enc_valid  = |{d_rise, o_rise, e_rise};
            if (enc_valid) enc_event = decode(d_rise, o_rise, e_rise);
            digit_prev = digit_pad;
            op_prev    = op_pad;
            equal_prev = equal_btn;
            complete_prev = complete;
        end
        busy = enc_valid || (fifo_q.size() != 0) || (wait_cnt != 0) || (expect_q.size() != 0);
    end

endmodule

/* test/calc_tb.sv */
// Calculator testbench: clock, reset, seeded random keystrokes, timeout and DUT
`include "calc_consts.svh"

module calc_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_EXPR   = 48;
    localparam int DIRECTED   = 10;
    localparam int SPACING    = 40;
    localparam int MAX_CYCLES = NUM_EXPR * 12 * SPACING + 2000;
    localparam logic [31:0] SEED = 32'h4294359e;
    // op_pad bit order
    localparam int BTN_NEG = 0;
    localparam int BTN_ADD = 1;
    localparam int BTN_SUB = 2;
    localparam int BTN_MUL = 3;

    logic                   clk;
    logic                   nRST;
    logic [9:0]             digit_pad;
    logic [3:0]             op_pad;
    logic                   equal_btn;
    logic [`CALC_WIDTH-1:0] display_output;
    logic                   complete;
    logic                   key_dropped;
    int                     mismatches;
    int                     other_errors;
    int                     results;
    logic                   busy;
    int                     cycles;

    calc_top DUT (
        .clk            (clk),
        .nRST           (nRST),
        .digit_pad      (digit_pad),
        .op_pad         (op_pad),
        .equal_btn      (equal_btn),
        .display_output (display_output),
        .complete       (complete),
        .key_dropped    (key_dropped)
    );

    calc_checker result_check (
        .clk            (clk),
        .nRST           (nRST),
        .digit_pad      (digit_pad),
        .op_pad         (op_pad),
        .equal_btn      (equal_btn),
        .display_output (display_output),
        .complete       (complete),
        .key_dropped    (key_dropped),
        .mismatches     (mismatches),
        .other_errors   (other_errors),
        .results        (results),
        .busy           (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // Button held one cycle, released one cycle, next press gap cycles after this one
    task automatic push_buttons(input logic [9:0] d, input logic [3:0] o, input logic e,
                                input int gap);
        @(posedge clk);
        #5;
        digit_pad = d;
        op_pad    = o;
        equal_btn = e;
        @(posedge clk);
        #5;
        digit_pad = '0;
        op_pad    = '0;
        equal_btn = 1'b0;
        repeat (gap - 2) @(posedge clk);
    endtask

    task automatic type_digit(input int d, input int gap);
        push_buttons(10'(1 << d), 4'b0, 1'b0, gap);
    endtask

    task automatic choose_op(input int b, input int gap);
        push_buttons(10'b0, 4'(1 << b), 1'b0, gap);
    endtask

    task automatic hit_equal(input int gap);
        push_buttons(10'b0, 4'b0, 1'b1, gap);
    endtask

    task automatic enter_number(input int value);
        int digits[$];
        int v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) type_digit(digits[i], SPACING);
    endtask

    task automatic directed_expression(input int a, input logic a_neg, input int op_bit,
                                       input int b, input logic b_neg);
        enter_number(a);
        if (a_neg) choose_op(BTN_NEG, SPACING);
        choose_op(op_bit, SPACING);
        enter_number(b);
        if (b_neg) choose_op(BTN_NEG, SPACING);
        hit_equal(SPACING);
    endtask

    // NEG may land before, between or after the digits
    task automatic random_operand(input int n);
        int neg_at;
        neg_at = ($urandom_range(0, 2) == 0) ? int'($urandom_range(0, n)) : -1;
        for (int i = 0; i <= n; i++) begin
            if (i == neg_at) choose_op(BTN_NEG, SPACING);
            if (i < n) type_digit($urandom_range(0, 9), SPACING);
        end
    endtask

    task automatic random_expression();
        random_operand($urandom_range(1, 4));
        choose_op($urandom_range(BTN_ADD, BTN_MUL), SPACING);
        random_operand($urandom_range(1, 4));
        hit_equal(SPACING);
    endtask

    // Six keys arrive during a multiply; the FIFO keeps four
    task automatic burst_during_multiply();
        enter_number(7);
        choose_op(BTN_MUL, SPACING);
        enter_number(8);
        hit_equal(2);
        type_digit(3, 2);
        choose_op(BTN_ADD, 2);
        type_digit(4, 2);
        hit_equal(2);
        type_digit(5, 2);
        type_digit(6, SPACING);
        repeat (2 * SPACING) @(posedge clk);
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            quiet = busy ? 0 : quiet + 1;
        end
    endtask

    initial begin
        int errors;
        nRST      = 1'b0;
        digit_pad = '0;
        op_pad    = '0;
        equal_btn = 1'b0;
        void'($urandom(SEED));
        repeat (16) @(posedge clk);
        #5;
        nRST = 1'b1;
        repeat (8) @(posedge clk);

        // Stray equal, then ADD replaced by MUL
        hit_equal(SPACING);
        enter_number(12);
        choose_op(BTN_ADD, SPACING);
        choose_op(BTN_MUL, SPACING);
        enter_number(3);
        hit_equal(SPACING);
        directed_expression(0, 1'b0, BTN_SUB, 0, 1'b0);
        directed_expression(5, 1'b1, BTN_SUB, 5, 1'b0);
        directed_expression(3, 1'b1, BTN_ADD, 3, 1'b0);
        directed_expression(9999, 1'b0, BTN_MUL, 9999, 1'b0);
        directed_expression(123, 1'b1, BTN_MUL, 45, 1'b1);
        directed_expression(30000, 1'b0, BTN_ADD, 9999, 1'b0);
        directed_expression(99999, 1'b0, BTN_SUB, 1, 1'b1);
        for (int n = 0; n < NUM_EXPR - DIRECTED; n++) random_expression();
        burst_during_multiply();
        wait_idle();

        errors = mismatches + other_errors;
        if (results == 0) begin
            $display("No calculator results were checked");
            errors++;
        end
        $display("Checked %0d results: %0d mismatches, %0d other errors",
                 results, mismatches, other_errors);
        if (errors == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/calc_pkg.sv
source/key_encoder.sv
source/key_fifo.sv
gencon/addition.sv
gencon/multiply.sv
gencon/gencon.sv
source/calc_top.sv
test/calc_checker.sv
test/calc_tb.sv

/* Makefile */
# Verilator build and run of the calculator testbench
SIM = obj_dir/Vcalc_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module calc_tb -f verilog.f

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
